// ==== fpAddTop.f ====
+incdir+common
common/fpAddPkg.sv
fpAdder/alignment.sv
fpAdder/specialCases.sv
fpAdder/normalizeRound.sv
design/axiLiteRegs.sv
design/fpAddTop.sv
sim/fpAddTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the adder testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module fpAddTb -f fpAddTop.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

simOutput=$(./obj_dir/VfpAddTb)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qx "RESULT: PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== sim/fpAddTb.sv ====
// Testbench for the AXI4-Lite float adder with stimulus table, random pairs and register checks
`timescale 1ns/1ps
`include "fpAdd_consts.svh"

module fpAddTb;

    localparam int WAIT_LIMIT = 50;
    localparam int POLL_LIMIT = 20;
    localparam int RANDOM_PAIRS = 20;

    typedef struct packed
    {
        fpAddPkg::floatWord a;
        fpAddPkg::floatWord b;
        fpAddPkg::floatWord expected;
        fpAddPkg::addFlags  expFlags;
    } addCase;

    logic                 clk;
    logic                 rstN;
    fpAddPkg::axiLiteReq  axiReq;
    fpAddPkg::axiLiteRsp  axiRsp;
    addCase               cases[$];
    int                   errorCount;
    int                   timeoutCount;

    fpAddTop fpAddTop_i
    (
        .clk    (clk),
        .rstN   (rstN),
        .axiReq (axiReq),
        .axiRsp (axiRsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic reportTimeout(input string what);
        timeoutCount++;
        $display("timeout at %0d ns: %s never arrived", $time, what);
    endtask

    task automatic checkFloat(input string name, input fpAddPkg::floatWord expected,
                              input fpAddPkg::floatWord actual);
        if (expected.raw !== actual.raw)
        begin
            errorCount++;
            $display("error at %0d ns: %s expected %h, got %h", $time, name,
                     expected.raw, actual.raw);
        end
    endtask

    task automatic checkFlags(input string name, input fpAddPkg::addFlags expected,
                              input fpAddPkg::addFlags actual);
        if (expected !== actual)
        begin
            errorCount++;
            $display("error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic checkResp(input string name, input logic [1:0] expected,
                             input logic [1:0] actual);
        if (expected !== actual)
        begin
            errorCount++;
            $display("error at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkData(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual)
        begin
            errorCount++;
            $display("error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        int waitCount;
        @(negedge clk);
        axiReq.awaddr = addr;
        axiReq.wdata = data;
        axiReq.awvalid = 1'b1;
        axiReq.wvalid = 1'b1;
        axiReq.bready = 1'b1;
        waitCount = 0;
        while (!(axiRsp.awready && axiRsp.wready) && waitCount < WAIT_LIMIT)
        begin
            @(negedge clk);
            waitCount++;
        end
        if (!(axiRsp.awready && axiRsp.wready))
            reportTimeout("awready and wready");
        // Handshake on the coming rising edge
        @(negedge clk);
        axiReq.awvalid = 1'b0;
        axiReq.wvalid = 1'b0;
        waitCount = 0;
        while (!axiRsp.bvalid && waitCount < WAIT_LIMIT)
        begin
            @(negedge clk);
            waitCount++;
        end
        if (!axiRsp.bvalid)
            reportTimeout("bvalid");
        resp = axiRsp.bresp;
        @(negedge clk);
        axiReq.bready = 1'b0;
    endtask

    // holdCycles keeps rready low that long once rvalid is up
    task automatic axiRead(input logic [7:0] addr, input int holdCycles,
                           output logic [31:0] data, output logic [1:0] resp);
        int waitCount;
        @(negedge clk);
        axiReq.araddr = addr;
        axiReq.arvalid = 1'b1;
        axiReq.rready = 1'b0;
        waitCount = 0;
        while (!axiRsp.arready && waitCount < WAIT_LIMIT)
        begin
            @(negedge clk);
            waitCount++;
        end
        if (!axiRsp.arready)
            reportTimeout("arready");
        @(negedge clk);
        axiReq.arvalid = 1'b0;
        waitCount = 0;
        while (!axiRsp.rvalid && waitCount < WAIT_LIMIT)
        begin
            @(negedge clk);
            waitCount++;
        end
        if (!axiRsp.rvalid)
            reportTimeout("rvalid");
        data = axiRsp.rdata;
        resp = axiRsp.rresp;
        for (int i = 0; i < holdCycles; i++)
        begin
            @(negedge clk);
            if (!axiRsp.rvalid)
            begin
                errorCount++;
                $display("rvalid dropped at %0d ns while rready was still low", $time);
            end
            checkData("rdata while stalled", data, axiRsp.rdata);
        end
        axiReq.rready = 1'b1;
        @(negedge clk);
        axiReq.rready = 1'b0;
    endtask

    task automatic pollDone(output logic [31:0] status);
        int pollCount;
        logic [1:0] resp;
        pollCount = 0;
        status = 32'd0;
        while (!status[0] && pollCount < POLL_LIMIT)
        begin
            axiRead(`REG_STATUS, 0, status, resp);
            pollCount++;
        end
        if (!status[0])
            reportTimeout("status done bit");
    endtask

    task automatic runAdd(input fpAddPkg::floatWord a, input fpAddPkg::floatWord b,
                          output fpAddPkg::floatWord sum, output fpAddPkg::addFlags fl);
        logic [1:0]  resp;
        logic [31:0] data;
        logic [31:0] status;
        axiWrite(`REG_OPA, a.raw, resp);
        checkResp("bresp opA", 2'b00, resp);
        axiWrite(`REG_OPB, b.raw, resp);
        checkResp("bresp opB", 2'b00, resp);
        axiWrite(`REG_CTRL, 32'd1, resp);
        checkResp("bresp ctrl", 2'b00, resp);
        pollDone(status);
        // Status bits 4:2 carry invalid, overflow, inexact
        fl = status[4:2];
        axiRead(`REG_RESULT, 0, data, resp);
        checkResp("rresp result", 2'b00, resp);
        sum.raw = data;
    endtask

    task automatic addEntry(input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] expected, input fpAddPkg::addFlags expFlags);
        addCase entry;
        entry.a.raw = a;
        entry.b.raw = b;
        entry.expected.raw = expected;
        entry.expFlags = expFlags;
        cases.push_back(entry);
    endtask

    // Equal exponents and signs always carry and drop one bit into guard
    task automatic sameExponentSum(input fpAddPkg::floatWord a, input fpAddPkg::floatWord b,
                                   output fpAddPkg::floatWord sum,
                                   output fpAddPkg::addFlags fl);
        logic [24:0] total;
        logic [24:0] roundedMant;
        logic [8:0]  exponent;
        total = {2'b01, a.f.mantissa} + {2'b01, b.f.mantissa};
        fl = 3'b000;
        fl.inexact = total[0];
        // Halfway case rounds up only when the kept lsb is odd
        roundedMant = {1'b0, total[24:1]} + {24'd0, total[0] & total[1]};
        exponent = {1'b0, a.f.exponent} + 9'd1;
        if (roundedMant[24])
        begin
            exponent = exponent + 9'd1;
            roundedMant = roundedMant >> 1;
        end
        sum.f.sign = a.f.sign;
        sum.f.exponent = exponent[7:0];
        sum.f.mantissa = roundedMant[22:0];
    endtask

    initial
    begin
        fpAddPkg::floatWord opA;
        fpAddPkg::floatWord opB;
        fpAddPkg::floatWord sum;
        fpAddPkg::floatWord expSum;
        fpAddPkg::addFlags  fl;
        fpAddPkg::addFlags  expFl;
        logic [31:0]        data;
        logic [1:0]         resp;

        errorCount = 0;
        timeoutCount = 0;
        void'($urandom(42309));
        rstN = 1'b0;
        axiReq = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        axiRead(`REG_STATUS, 0, data, resp);
        checkData("status after reset", 32'd0, data);
        checkResp("rresp status", 2'b00, resp);

        // Flags column is {invalid, overflow, inexact}
        addEntry(32'h3FC00000, 32'h3FE00000, 32'h40500000, 3'b000);
        addEntry(32'h3F800000, 32'h3F000000, 32'h3FC00000, 3'b000);
        addEntry(32'h3F800000, 32'h3D000000, 32'h3F840000, 3'b000);
        addEntry(32'h3F800000, 32'h30800000, 32'h3F800000, 3'b001);
        addEntry(32'h3FC00000, 32'hBFA00000, 32'h3E800000, 3'b000);
        addEntry(32'h40490FDB, 32'hC0490FDB, 32'h00000000, 3'b000);
        addEntry(32'h3F800000, 32'hB3000000, 32'h3F800000, 3'b001);
        addEntry(32'h3F800000, 32'h33800000, 32'h3F800000, 3'b001);
        addEntry(32'h3F800001, 32'h33800000, 32'h3F800002, 3'b001);
        addEntry(32'h7FC00000, 32'h3F800000, 32'h7FC00000, 3'b000);
        addEntry(32'h7F800001, 32'h3F800000, 32'h7FC00000, 3'b000);
        addEntry(32'h7F800000, 32'hFF800000, 32'h7FC00000, 3'b100);
        addEntry(32'hFF800000, 32'h3F800000, 32'hFF800000, 3'b000);
        addEntry(32'h00000000, 32'h40490FDB, 32'h40490FDB, 3'b000);
        addEntry(32'h80000000, 32'h80000000, 32'h80000000, 3'b000);
        addEntry(32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F800000, 3'b011);
        addEntry(32'h00400000, 32'h00400000, 32'h00800000, 3'b000);
        addEntry(32'h00000001, 32'h00800000, 32'h00800001, 3'b000);

        for (int i = 0; i < cases.size(); i++)
        begin
            runAdd(cases[i].a, cases[i].b, sum, fl);
            checkFloat($sformatf("result[%0d]", i), cases[i].expected, sum);
            checkFlags($sformatf("flags[%0d]", i), cases[i].expFlags, fl);
        end

        // Exponents up to 252 keep the sum below the overflow range
        for (int n = 0; n < RANDOM_PAIRS; n++)
        begin
            opA.f.sign = 1'($urandom);
            opA.f.exponent = 8'(32'd1 + ($urandom % 32'd252));
            opA.f.mantissa = 23'($urandom);
            opB.f.sign = opA.f.sign;
            opB.f.exponent = opA.f.exponent;
            opB.f.mantissa = 23'($urandom);
            sameExponentSum(opA, opB, expSum, expFl);
            runAdd(opA, opB, sum, fl);
            checkFloat($sformatf("random result[%0d]", n), expSum, sum);
            checkFlags($sformatf("random flags[%0d]", n), expFl, fl);
        end

        axiWrite(`REG_OPA, 32'h3F800000, resp);
        checkResp("bresp opA", 2'b00, resp);
        axiRead(`REG_STATUS, 0, data, resp);
        checkData("status busy/done after operand write", 32'd0, data & 32'h3);

        axiWrite(8'h20, 32'h12345678, resp);
        checkResp("bresp unmapped", 2'b10, resp);
        axiRead(8'h20, 0, data, resp);
        checkResp("rresp unmapped", 2'b10, resp);

        axiRead(`REG_RESULT, 6, data, resp);
        checkData("result under back-pressure", expSum.raw, data);
        checkResp("rresp result", 2'b00, resp);

        $display("Adder run finished with %0d errors and %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== design/fpAddTop.sv ====
// Adder top level with register block, alignment, special cases and normalize/round stages
`timescale 1ns/1ps

module fpAddTop
(
    input  logic                  clk,
    input  logic                  rstN,
    input  fpAddPkg::axiLiteReq   axiReq,
    output fpAddPkg::axiLiteRsp   axiRsp
);

    fpAddPkg::floatWord     operandA;
    fpAddPkg::floatWord     operandB;
    fpAddPkg::floatWord     result;
    fpAddPkg::addFlags      flags;
    fpAddPkg::alignResult   align;
    fpAddPkg::specialResult special;
    logic                   start;
    logic                   alignValid;
    logic                   specialValid;
    logic                   resultValid;

    axiLiteRegs axiLiteRegs_i
    (
        .clk         (clk),
        .rstN        (rstN),
        .axiReq      (axiReq),
        .result      (result),
        .flags       (flags),
        .resultValid (resultValid),
        .axiRsp      (axiRsp),
        .operandA    (operandA),
        .operandB    (operandB),
        .start       (start)
    );

    alignment alignment_i
    (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .operandA   (operandA),
        .operandB   (operandB),
        .align      (align),
        .alignValid (alignValid)
    );

    specialCases specialCases_i
    (
        .clk          (clk),
        .rstN         (rstN),
        .start        (start),
        .operandA     (operandA),
        .operandB     (operandB),
        .special      (special),
        .specialValid (specialValid)
    );

    normalizeRound normalizeRound_i
    (
        .clk          (clk),
        .rstN         (rstN),
        .align        (align),
        .alignValid   (alignValid),
        .special      (special),
        .specialValid (specialValid),
        .result       (result),
        .flags        (flags),
        .resultValid  (resultValid)
    );

endmodule

// ==== design/axiLiteRegs.sv ====
// AXI4-Lite slave with operand, control, status and result registers and start/done sequencing
`timescale 1ns/1ps
`include "fpAdd_consts.svh"

module axiLiteRegs
(
    input  logic                  clk,
    input  logic                  rstN,
    input  fpAddPkg::axiLiteReq   axiReq,
    input  fpAddPkg::floatWord    result,
    input  fpAddPkg::addFlags     flags,
    input  logic                  resultValid,
    output fpAddPkg::axiLiteRsp   axiRsp,
    output fpAddPkg::floatWord    operandA,
    output fpAddPkg::floatWord    operandB,
    output logic                  start
);

    logic                 awReady;
    logic                 bValid;
    logic [1:0]           bResp;
    logic                 arReady;
    logic                 rValid;
    logic [1:0]           rResp;
    logic [31:0]          rData;
    logic                 busy;
    logic                 done;
    fpAddPkg::floatWord   resultReg;
    fpAddPkg::addFlags    flagsReg;
    logic                 wrFire;
    logic                 rdFire;
    logic                 wrHit;
    logic                 rdHit;
    logic [31:0]          rdValue;

    // AW and W are taken together in one handshake
    assign wrFire = awReady && axiReq.awvalid && axiReq.wvalid;
    assign rdFire = arReady && axiReq.arvalid;

    always_comb
    begin
        case (axiReq.awaddr)
            `REG_OPA, `REG_OPB, `REG_CTRL, `REG_STATUS, `REG_RESULT: wrHit = 1'b1;
            default: wrHit = 1'b0;
        endcase
    end

    always_comb
    begin
        rdHit = 1'b1;
        case (axiReq.araddr)
            `REG_OPA:    rdValue = operandA.raw;
            `REG_OPB:    rdValue = operandB.raw;
            `REG_CTRL:   rdValue = 32'd0;
            `REG_STATUS: rdValue = {27'd0, flagsReg, busy, done};
            `REG_RESULT: rdValue = resultReg.raw;
            default:
            begin
                rdHit = 1'b0;
                rdValue = 32'd0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            awReady <= 1'b0;
            bValid <= 1'b0;
            bResp <= 2'b00;
            start <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            flagsReg <= '0;
        end
        else
        begin
            start <= 1'b0;
            awReady <= axiReq.awvalid && axiReq.wvalid && !awReady && !bValid;
            if (wrFire)
            begin
                bValid <= 1'b1;
                bResp <= wrHit ? 2'b00 : 2'b10;
                if (axiReq.awaddr == `REG_OPA || axiReq.awaddr == `REG_OPB)
                    done <= 1'b0;
                // Start while busy is dropped
                if (axiReq.awaddr == `REG_CTRL && axiReq.wdata[0] && !busy)
                begin
                    start <= 1'b1;
                    busy <= 1'b1;
                    done <= 1'b0;
                end
            end
            else if (bValid && axiReq.bready)
                bValid <= 1'b0;

            if (resultValid)
            begin
                done <= 1'b1;
                busy <= 1'b0;
                flagsReg <= flags;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wrFire && axiReq.awaddr == `REG_OPA)
            operandA.raw <= axiReq.wdata;
        if (wrFire && axiReq.awaddr == `REG_OPB)
            operandB.raw <= axiReq.wdata;
        if (resultValid)
            resultReg <= result;
    end

    // Read channel, response held until rready
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            arReady <= 1'b0;
            rValid <= 1'b0;
        end
        else if (rdFire)
        begin
            arReady <= 1'b0;
            rValid <= 1'b1;
        end
        else if (rValid && axiReq.rready)
        begin
            arReady <= 1'b1;
            rValid <= 1'b0;
        end
        else if (!rValid)
            arReady <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rdFire)
        begin
            rData <= rdValue;
            rResp <= rdHit ? 2'b00 : 2'b10;
        end
    end

    assign axiRsp.awready = awReady;
    assign axiRsp.wready  = awReady;
    assign axiRsp.bresp   = bResp;
    assign axiRsp.bvalid  = bValid;
    assign axiRsp.arready = arReady;
    assign axiRsp.rdata   = rData;
    assign axiRsp.rresp   = rResp;
    assign axiRsp.rvalid  = rValid;

endmodule

// ==== fpAdder/normalizeRound.sv ====
// Mantissa add/subtract, normalization, round to nearest-even, flags and result register
`timescale 1ns/1ps
`include "fpAdd_consts.svh"

module normalizeRound
(
    input  logic                    clk,
    input  logic                    rstN,
    input  fpAddPkg::alignResult    align,
    input  logic                    alignValid,
    input  fpAddPkg::specialResult  special,
    input  logic                    specialValid,
    output fpAddPkg::floatWord      result,
    output fpAddPkg::addFlags       flags,
    output logic                    resultValid
);

    logic [7:0]           lowA;
    logic [7:0]           lowB;
    logic [32:0]          extA;
    logic [32:0]          extB;
    logic [32:0]          magnitude;
    logic                 sumSign;
    logic [5:0]           lzCount;
    logic [31:0]          normWord;
    logic signed [9:0]    normExp;
    logic signed [9:0]    finalExp;
    logic                 normGuard;
    logic                 normRound;
    logic                 normSticky;
    logic                 roundUp;
    logic [24:0]          rounded;
    fpAddPkg::floatWord   resultNext;
    fpAddPkg::addFlags    flagsNext;

    function automatic logic [5:0] countLeadingZeros(input logic [31:0] value);
        logic [5:0] count;
        logic found;
        count = 6'd32;
        found = 1'b0;
        for (int i = 31; i >= 0; i--)
        begin
            if (value[i] && !found)
            begin
                count = 6'(31 - i);
                found = 1'b1;
            end
        end
        return count;
    endfunction

    // Guard/round/sticky belong to the shifted operand, whose hidden bit is clear
    always_comb
    begin
        lowA = align.alignedMantissaA[31] ? 8'd0 :
               {align.guardBit, align.roundBit, 5'd0, align.stickyBit};
        lowB = align.alignedMantissaB[31] ? 8'd0 :
               {align.guardBit, align.roundBit, 5'd0, align.stickyBit};
        extA = {1'b0, align.alignedMantissaA[31:8], lowA};
        extB = {1'b0, align.alignedMantissaB[31:8], lowB};

        if (align.signA == align.signB)
        begin
            magnitude = extA + extB;
            sumSign = align.signA;
        end
        else if (extA >= extB)
        begin
            magnitude = extA - extB;
            sumSign = align.signA;
        end
        else
        begin
            magnitude = extB - extA;
            sumSign = align.signB;
        end
        // Exact cancellation is +0
        if (magnitude == 33'd0)
            sumSign = 1'b0;
    end

    always_comb
    begin
        lzCount = countLeadingZeros(magnitude[31:0]);
        if (magnitude[32])
        begin
            normWord = {magnitude[32:2], magnitude[1] | magnitude[0]};
            normExp = 10'(align.exponentOut) + 10'sd1;
        end
        else
        begin
            normWord = magnitude[31:0] << lzCount;
            normExp = 10'(align.exponentOut) - 10'(lzCount);
        end

        normGuard = normWord[7];
        normRound = normWord[6];
        normSticky = |normWord[5:0];
        roundUp = normGuard && (normRound || normSticky || normWord[8]);
        rounded = {1'b0, normWord[31:8]} + 25'(roundUp);
        // Carry out of rounding renormalizes
        finalExp = normExp + 10'(rounded[24]);
    end

    always_comb
    begin
        flagsNext = '0;
        resultNext.raw = 32'd0;
        if (special.bypass)
        begin
            resultNext.raw = special.bypassValue;
            flagsNext.invalid = special.invalid;
        end
        else if (magnitude == 33'd0)
            resultNext.raw = 32'd0;
        else if (normExp <= 0)
        begin
            // Too small for a normal result, flush to signed zero
            resultNext.raw = {sumSign, 31'd0};
            flagsNext.inexact = 1'b1;
        end
        else if (finalExp >= `FP_EXP_MAX)
        begin
            resultNext.raw = {sumSign, 8'(`FP_EXP_MAX), 23'd0};
            flagsNext.overflow = 1'b1;
            flagsNext.inexact = 1'b1;
        end
        else
        begin
            resultNext.f.sign = sumSign;
            resultNext.f.exponent = finalExp[7:0];
            resultNext.f.mantissa = rounded[24] ? rounded[23:1] : rounded[22:0];
            flagsNext.inexact = normGuard || normRound || normSticky;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            resultValid <= 1'b0;
        else
            resultValid <= alignValid && specialValid;
    end

    always_ff @(posedge clk)
    begin
        if (alignValid && specialValid)
        begin
            result <= resultNext;
            flags <= flagsNext;
        end
    end

endmodule

// ==== fpAdder/specialCases.sv ====
// Operand classification and bypass result selection
`timescale 1ns/1ps
`include "fpAdd_consts.svh"

module specialCases
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    start,
    input  fpAddPkg::floatWord      operandA,
    input  fpAddPkg::floatWord      operandB,
    output fpAddPkg::specialResult  special,
    output logic                    specialValid
);

    fpAddPkg::floatClass     classA;
    fpAddPkg::floatClass     classB;
    fpAddPkg::specialResult  specialNext;

    function automatic fpAddPkg::floatClass classify(input fpAddPkg::floatWord word);
        fpAddPkg::floatClass cls;
        logic expOnes;
        logic expZero;
        logic mantZero;
        expOnes = &word.f.exponent;
        expZero = (word.f.exponent == 8'd0);
        mantZero = (word.f.mantissa == 23'd0);
        cls.isNaN = expOnes && !mantZero;
        cls.isInf = expOnes && mantZero;
        cls.isZero = expZero && mantZero;
        cls.isSub = expZero && !mantZero;
        cls.isSignaling = cls.isNaN && !word.f.mantissa[22];
        cls.pad = 1'b0;
        return cls;
    endfunction

    assign classA = classify(operandA);
    assign classB = classify(operandB);

    always_comb
    begin
        specialNext.bypass = 1'b1;
        specialNext.invalid = 1'b0;
        specialNext.pad = 1'b0;
        if (classA.isNaN || classB.isNaN)
            specialNext.bypassValue = `FP_QNAN;
        else if (classA.isInf && classB.isInf && operandA.f.sign != operandB.f.sign)
        begin
            specialNext.bypassValue = `FP_QNAN;
            specialNext.invalid = 1'b1;
        end
        else if (classA.isInf)
            specialNext.bypassValue = operandA.raw;
        else if (classB.isInf)
            specialNext.bypassValue = operandB.raw;
        // -0 only when both zeros are negative
        else if (classA.isZero && classB.isZero)
            specialNext.bypassValue = {operandA.f.sign & operandB.f.sign, 31'd0};
        else if (classA.isZero)
            specialNext.bypassValue = operandB.raw;
        else if (classB.isZero)
            specialNext.bypassValue = operandA.raw;
        else
        begin
            specialNext.bypass = 1'b0;
            specialNext.bypassValue = 32'd0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            specialValid <= 1'b0;
        else
            specialValid <= start;
    end

    always_ff @(posedge clk)
    begin
        if (start)
            special <= specialNext;
    end

endmodule

// ==== fpAdder/alignment.sv ====
// Exponent compare, mantissa alignment shift and guard/round/sticky generation
`timescale 1ns/1ps
`include "fpAdd_consts.svh"

module alignment
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  start,
    input  fpAddPkg::floatWord    operandA,
    input  fpAddPkg::floatWord    operandB,
    output fpAddPkg::alignResult  align,
    output logic                  alignValid
);

    logic [7:0]            effExpA;
    logic [7:0]            effExpB;
    logic [31:0]           mantA;
    logic [31:0]           mantB;
    logic                  aLarger;
    logic [7:0]            expDiff;
    logic [31:0]           smallMant;
    logic [31:0]           shiftedMant;
    logic [31:0]           alignedSmall;
    fpAddPkg::alignResult  alignNext;

    // Subnormals get hidden bit 0 and count as exponent 1
    always_comb
    begin
        effExpA = (operandA.f.exponent == 8'd0) ? 8'd1 : operandA.f.exponent;
        effExpB = (operandB.f.exponent == 8'd0) ? 8'd1 : operandB.f.exponent;
        mantA = {operandA.f.exponent != 8'd0, operandA.f.mantissa, 8'b0};
        mantB = {operandB.f.exponent != 8'd0, operandB.f.mantissa, 8'b0};
    end

    always_comb
    begin
        aLarger = (effExpA >= effExpB);
        if (aLarger)
        begin
            alignNext.exponentOut = effExpA;
            expDiff = effExpA - effExpB;
            smallMant = mantB;
        end
        else
        begin
            alignNext.exponentOut = effExpB;
            expDiff = effExpB - effExpA;
            smallMant = mantA;
        end
        shiftedMant = smallMant >> expDiff;

        if (expDiff > `FP_STICKY_LIMIT)
        begin
            alignedSmall = 32'd0;
            alignNext.guardBit = 1'b0;
            alignNext.roundBit = 1'b0;
            alignNext.stickyBit = |smallMant;
        end
        else
        begin
            // Bits below the round position, including those shifted out
            alignedSmall = {shiftedMant[31:8], 8'b0};
            alignNext.guardBit = shiftedMant[7];
            alignNext.roundBit = shiftedMant[6];
            alignNext.stickyBit = |(smallMant & ((32'd1 << (expDiff + 8'd6)) - 32'd1));
        end

        alignNext.alignedMantissaA = aLarger ? mantA : alignedSmall;
        alignNext.alignedMantissaB = aLarger ? alignedSmall : mantB;
        alignNext.signA = operandA.f.sign;
        alignNext.signB = operandB.f.sign;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            alignValid <= 1'b0;
        else
            alignValid <= start;
    end

    always_ff @(posedge clk)
    begin
        if (start)
            align <= alignNext;
    end

endmodule

// ==== common/fpAddPkg.sv ====
// Float word union, operand class flags, stage result structs and AXI4-Lite channel structs
package fpAddPkg;

    typedef struct packed
    {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } floatFields;

    // Raw register word, or the IEEE-754 binary32 fields
    typedef union packed
    {
        logic [31:0] raw;
        floatFields  f;
    } floatWord;

    typedef struct packed
    {
        logic isNaN;
        logic isInf;
        logic isZero;
        logic isSub;
        logic isSignaling;
        logic pad;
    } floatClass;

    // Hidden bit, 23 fraction bits, 8 extension bits
    typedef struct packed
    {
        logic [7:0]  exponentOut;
        logic [31:0] alignedMantissaA;
        logic [31:0] alignedMantissaB;
        logic        guardBit;
        logic        roundBit;
        logic        stickyBit;
        logic        signA;
        logic        signB;
    } alignResult;

    typedef struct packed
    {
        logic        bypass;
        logic [31:0] bypassValue;
        logic        invalid;
        logic        pad;
    } specialResult;

    typedef struct packed
    {
        logic invalid;
        logic overflow;
        logic inexact;
    } addFlags;

    // Master to slave
    typedef struct packed
    {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axiLiteReq;

    // Slave to master
    typedef struct packed
    {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axiLiteRsp;

endpackage

// ==== common/fpAdd_consts.svh ====
// Float format constants and register offsets of the adder
`ifndef FP_ADD_CONSTS_SVH
`define FP_ADD_CONSTS_SVH

`define FP_BIAS 127
`define FP_EXP_MAX 255
`define FP_QNAN 32'h7FC00000

// Shift distance past which the whole mantissa only feeds sticky
`define FP_STICKY_LIMIT 26

`define REG_OPA 8'h00
`define REG_OPB 8'h04
`define REG_CTRL 8'h08
`define REG_STATUS 8'h0C
`define REG_RESULT 8'h10

`endif
